// ==== sim.f ====
+incdir+include
logic/bp_pkg.sv
logic/inst_predecode.sv
logic/branch_predictor.sv
logic/return_stack.sv
logic/next_pc_select.sv
logic/ifu.sv
dv/ifu_checker.sv
dv/ifu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ifu testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ifu_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vifu_tb +verilator+error+limit+1000); then
  printf '%s\n' "$out"
  echo "simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

// ==== dv/ifu_tb.sv ====
`include "bp_config.svh"

module ifu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import bp_pkg::*;

  localparam int TEST_CYCLES = 250;
  localparam int CYCLE_LIMIT = 16 + 6 * TEST_CYCLES + 100;  // reset, six tests, slack

  logic                 clk;
  logic                 reset_i = 1'b1;
  logic [`XLEN-1:0]     inst_addr_i = '0;
  logic                 if_rdata_valid_i = 1'b1;  // live fetch held in reset
  logic [`XLEN-1:0]     if_rdata_i = {25'd0, OP_JAL};  // jal would predict if not gated
  logic                 if_rdata_err_i = 1'b0;
  logic                 ex_branch_valid_i = 1'b0;
  logic                 ex_branch_taken_i = 1'b0;
  logic                 ex_pdt_true_i = 1'b1;
  logic [`XLEN-1:0]     ex_pc_i = '0;
  logic [`HISLEN-1:0]   ex_history_i = '0;
  logic                 id_ras_push_valid_i = 1'b0;
  logic [`XLEN-1:0]     id_ras_push_data_i = '0;
  logic                 ex_stall_valid_i = 1'b0;
  logic                 if_flush_i = 1'b0;
  logic                 ram_stall_valid_if_o;
  logic [`XLEN-1:0]     inst_addr_o;
  logic [`XLEN-1:0]     inst_data_o;
  logic [`TRAP_LEN-1:0] trap_bus_o;
  logic [`XLEN-1:0]     bpu_pc_o;
  logic                 bpu_pc_valid_o;
  logic                 pdt_res_o;
  logic [`HISLEN-1:0]   history_o;

  logic [1:0]         cnt_m [`BHT_ENTRIES];  // model counters
  logic [`HISLEN-1:0] hist_m = '0;
  logic [`XLEN-1:0]   ras_m [$];  // newest entry at the back
  logic [31:0]        rng_state = 32'd57;
  int                 errors = 0;
  int                 checks = 0;
  int                 failed_tests = 0;
  int                 cycle_count = 0;
  int                 taken_seen;
  int                 ret_seen;

  ifu i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles before the tests finished", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // word address bits xor history, wrapped to the table size
  function automatic int bht_index(input logic [`XLEN-1:0] pc, input logic [`HISLEN-1:0] h);
    return int'(((pc >> 2) ^ `XLEN'(h)) % `BHT_ENTRIES);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic drive_cycle(input int test);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] w;
    logic [1:0]  sel;
    logic        focus;
    r = next_rand();
    a = next_rand();
    w = next_rand();
    focus = (test == 3 || test == 5);
    sel = r[1:0];
    if (focus) a = {28'h0000100, a[3:2], 2'b00};  // four pcs on a few counters
    else if (test != 2 && r[31:29] != 3'd0) a[1:0] = 2'b00;
    if (focus && r[2]) sel = 2'd2;
    if (test == 4 && r[2]) sel = 2'd3;
    if (sel == 2'd1) w[6:0] = OP_JAL;
    if (sel == 2'd2) w[6:0] = OP_BRANCH;
    if (sel == 2'd3) w[19:0] = {(r[3] ? 5'd5 : 5'd1), 3'b000, 5'd0, OP_JALR};  // ret
    inst_addr_i         <= a;
    if_rdata_i          <= w;
    if_rdata_valid_i    <= (test == 6) ? r[4] : (r[6:4] != 3'd0);
    if_rdata_err_i      <= r[7] & r[8];
    if_flush_i          <= (test == 6) ? r[9] : (r[11:9] == 3'd0);
    ex_stall_valid_i    <= (test == 6) ? r[12] : (r[14:12] == 3'd0);
    id_ras_push_valid_i <= (test == 4 || test == 6) ? r[15] : (r[16:15] == 2'd0);
    id_ras_push_data_i  <= {a[31:2] ^ w[31:2], 2'b00};
    ex_branch_valid_i   <= focus ? r[17] : (r[18:17] == 2'd0);
    ex_branch_taken_i   <= (test == 3) ? (r[20:19] != 2'd0) : r[19];  // mostly taken in 3
    ex_pdt_true_i       <= (test == 5) ? r[21] : (r[22:21] != 2'd0);
    ex_pc_i             <= focus ? {28'h0000100, r[24:23], 2'b00} : (w ^ a);
    ex_history_i        <= (test == 3) ? `HISLEN'(r[26:25]) : `HISLEN'(r[28:25]);
  endtask

  // compare outputs with the model, then advance the model past the next edge
  task automatic check_cycle();
    logic [`XLEN-1:0]     w;
    logic [`XLEN-1:0]     off;
    logic [`XLEN-1:0]     exp_pc;
    logic [`TRAP_LEN-1:0] exp_trap;
    logic [6:0]           op;
    logic [4:0]           rs1;
    logic                 fetch_en;
    logic                 pred;
    logic                 pop;
    logic                 exp_valid;
    inst_kind_e           kind;
    int                   widx;
    w = if_rdata_i;
    op = w[6:0];
    rs1 = w[19:15];
    kind = KIND_NONE;
    if (op == OP_JAL) kind = KIND_JAL;
    if (op == OP_BRANCH) kind = KIND_BRANCH;
    if (op == OP_JALR && w[11:7] == 5'd0 && (rs1 == 5'd1 || rs1 == 5'd5)) kind = KIND_RET;
    off = (kind == KIND_JAL) ? {{(`XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0}
                             : {{(`XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    fetch_en = if_rdata_valid_i && !if_flush_i && !ex_stall_valid_i && !reset_i;
    pred = cnt_m[bht_index(inst_addr_i, hist_m)][1];
    pop = fetch_en && kind == KIND_RET && ras_m.size() > 0;
    exp_valid = fetch_en && (kind == KIND_JAL || (kind == KIND_BRANCH && pred) || pop);
    exp_pc = pop ? ras_m[ras_m.size() - 1] : inst_addr_i + off;
    exp_trap = '0;
    exp_trap[`TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0];
    exp_trap[`TRAP_INST_ACCESS_FAULT] = if_rdata_err_i;
    check_value("inst_addr_o", inst_addr_o, inst_addr_i);
    check_value("inst_data_o", inst_data_o, if_rdata_i);
    check_value("ram_stall_valid_if_o", 32'(ram_stall_valid_if_o), 32'(!if_rdata_valid_i));
    check_value("trap_bus_o", 32'(trap_bus_o), 32'(exp_trap));
    check_value("pdt_res_o", 32'(pdt_res_o), 32'(pred));
    check_value("history_o", 32'(history_o), 32'(hist_m));
    check_value("bpu_pc_valid_o", 32'(bpu_pc_valid_o), 32'(exp_valid));
    if (exp_valid) check_value("bpu_pc_o", bpu_pc_o, exp_pc);
    if (exp_valid && kind == KIND_BRANCH) taken_seen++;
    if (pop) ret_seen++;
    if (ex_branch_valid_i) begin
      widx = bht_index(ex_pc_i, ex_history_i);
      if (ex_branch_taken_i && cnt_m[widx] != 2'd3) cnt_m[widx] += 2'd1;
      if (!ex_branch_taken_i && cnt_m[widx] != 2'd0) cnt_m[widx] -= 2'd1;
    end
    if (ex_branch_valid_i && !ex_pdt_true_i) begin
      hist_m = {ex_history_i[`HISLEN-2:0], ex_branch_taken_i};  // repair beats the shift
    end else if (fetch_en && kind == KIND_BRANCH) begin
      hist_m = {hist_m[`HISLEN-2:0], pred};
    end
    if (pop && id_ras_push_valid_i) begin
      ras_m[ras_m.size() - 1] = id_ras_push_data_i;
    end else if (pop) begin
      void'(ras_m.pop_back());
    end else if (id_ras_push_valid_i) begin
      ras_m.push_back(id_ras_push_data_i);
      if (ras_m.size() > `RAS_DEPTH) void'(ras_m.pop_front());  // oldest falls off
    end
  endtask

  task automatic run_test(input int test, input string name);
    int errors_before;
    errors_before = errors;
    taken_seen = 0;
    ret_seen = 0;
    repeat (TEST_CYCLES) begin
      @(posedge clk);
      drive_cycle(test);
      @(negedge clk);
      check_cycle();
    end
    if (test == 3) begin
      assert (taken_seen > 0) else begin
        $display("test 3 never saw a branch predicted taken");
        errors++;
      end
    end
    if (test == 4) begin
      assert (ret_seen > 0) else begin
        $display("test 4 never saw a return predicted from the stack");
        errors++;
      end
    end
    if (errors == errors_before) begin
      $display("test %0d %s: ok", test, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test, name, errors - errors_before);
    end
  endtask

  initial begin
    for (int i = 0; i < `BHT_ENTRIES; i++) begin
      cnt_m[i] = 2'b01;  // weakly not taken
    end
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;
    run_test(1, "pass-through and stall");
    run_test(2, "trap bus");
    run_test(3, "jal and branches");
    run_test(4, "return stack");
    run_test(5, "history repair");
    run_test(6, "suppression");
    assert (i_dut.i_checker.fail_count == 0) else begin
      $display("bound checker saw %0d assertion failures", i_dut.i_checker.fail_count);
      errors++;
    end
    $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
             failed_tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== dv/ifu_checker.sv ====
`include "bp_config.svh"

module ifu_checker (
  input logic             clk,
  input logic             reset_i,
  input logic             bpu_pc_valid_i,
  input logic             stall_i,
  input logic [`XLEN-1:0] addr_in_i,
  input logic [`XLEN-1:0] addr_out_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // read by the testbench at the end

  // a prediction needs fetched data
  valid_needs_data: assert property (@(posedge clk) bpu_pc_valid_i |-> !stall_i)
    else begin
      $error("prediction valid while fetch is stalled");
      fail_count++;
    end

  no_valid_in_reset: assert property (@(posedge clk) reset_i |-> !bpu_pc_valid_i)
    else begin
      $error("prediction valid during reset");
      fail_count++;
    end

  addr_pass: assert property (@(posedge clk) addr_out_i == addr_in_i)
    else begin
      $error("inst_addr_o differs from inst_addr_i");
      fail_count++;
    end

endmodule

bind ifu ifu_checker i_checker (
  .clk            (clk),
  .reset_i        (reset_i),
  .bpu_pc_valid_i (bpu_pc_valid_o),
  .stall_i        (ram_stall_valid_if_o),
  .addr_in_i      (inst_addr_i),
  .addr_out_i     (inst_addr_o)
);

// ==== logic/ifu.sv ====
`include "bp_config.svh"

module ifu (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic [`XLEN-1:0]     inst_addr_i,  // from pc register
  input  logic                 if_rdata_valid_i,  // low while memory is busy
  input  logic [`XLEN-1:0]     if_rdata_i,
  input  logic                 if_rdata_err_i,
  input  logic                 ex_branch_valid_i,
  input  logic                 ex_branch_taken_i,
  input  logic                 ex_pdt_true_i,
  input  logic [`XLEN-1:0]     ex_pc_i,
  input  logic [`HISLEN-1:0]   ex_history_i,  // history seen at fetch
  input  logic                 id_ras_push_valid_i,  // call seen in decode
  input  logic [`XLEN-1:0]     id_ras_push_data_i,
  input  logic                 ex_stall_valid_i,
  input  logic                 if_flush_i,
  output logic                 ram_stall_valid_if_o,
  output logic [`XLEN-1:0]     inst_addr_o,  // to if/id
  output logic [`XLEN-1:0]     inst_data_o,
  output logic [`TRAP_LEN-1:0] trap_bus_o,
  output logic [`XLEN-1:0]     bpu_pc_o,  // to pc register
  output logic                 bpu_pc_valid_o,
  output logic                 pdt_res_o,  // to ex
  output logic [`HISLEN-1:0]   history_o
);

  import bp_pkg::*;

  inst_kind_e       kind;
  logic [`XLEN-1:0] offset;
  logic [`XLEN-1:0] ras_top;
  logic             ras_empty;
  logic             ras_pop;
  logic             fetch_en;

  assign inst_addr_o          = inst_addr_i;
  assign inst_data_o          = if_rdata_i;
  assign ram_stall_valid_if_o = !if_rdata_valid_i;  // stall until data arrives

  // speculative state only moves on a live fetch
  assign fetch_en = if_rdata_valid_i && !if_flush_i && !ex_stall_valid_i && !reset_i;

  always_comb begin
    trap_bus_o = '0;
    trap_bus_o[`TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0];
    trap_bus_o[`TRAP_INST_ACCESS_FAULT]    = if_rdata_err_i;
    trap_bus_o[`TRAP_INST_PAGE_FAULT]      = 1'b0;  // no mmu
  end

  inst_predecode i_predecode (
    .inst_i   (if_rdata_i),
    .kind_o   (kind),
    .offset_o (offset)
  );

  branch_predictor i_predictor (
    .clk               (clk),
    .reset_i           (reset_i),
    .fetch_en_i        (fetch_en),
    .pc_i              (inst_addr_i),
    .kind_i            (kind),
    .ex_branch_valid_i (ex_branch_valid_i),
    .ex_branch_taken_i (ex_branch_taken_i),
    .ex_pdt_true_i     (ex_pdt_true_i),
    .ex_pc_i           (ex_pc_i),
    .ex_history_i      (ex_history_i),
    .pdt_res_o         (pdt_res_o),
    .history_o         (history_o)
  );

  return_stack i_ras (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_i      (id_ras_push_valid_i),
    .push_data_i (id_ras_push_data_i),
    .pop_i       (ras_pop),
    .top_o       (ras_top),
    .empty_o     (ras_empty)
  );

  next_pc_select i_next_pc (
    .fetch_en_i     (fetch_en),
    .pc_i           (inst_addr_i),
    .kind_i         (kind),
    .offset_i       (offset),
    .pdt_res_i      (pdt_res_o),
    .ras_top_i      (ras_top),
    .ras_empty_i    (ras_empty),
    .bpu_pc_o       (bpu_pc_o),
    .bpu_pc_valid_o (bpu_pc_valid_o),
    .ras_pop_o      (ras_pop)
  );

endmodule

// ==== logic/next_pc_select.sv ====
`include "bp_config.svh"

module next_pc_select (
  input  logic               fetch_en_i,
  input  logic [`XLEN-1:0]   pc_i,
  input  bp_pkg::inst_kind_e kind_i,
  input  logic [`XLEN-1:0]   offset_i,
  input  logic               pdt_res_i,
  input  logic [`XLEN-1:0]   ras_top_i,
  input  logic               ras_empty_i,
  output logic [`XLEN-1:0]   bpu_pc_o,
  output logic               bpu_pc_valid_o,
  output logic               ras_pop_o
);

  import bp_pkg::*;

  logic             redirect;
  logic [`XLEN-1:0] pc_rel;

  assign pc_rel = pc_i + offset_i;

  always_comb begin
    redirect = 1'b0;
    bpu_pc_o = pc_i + `XLEN'd4;  // sequential when nothing is predicted
    case (kind_i)
      KIND_JAL: begin
        redirect = 1'b1;
        bpu_pc_o = pc_rel;
      end
      KIND_BRANCH: begin
        redirect = pdt_res_i;
        if (pdt_res_i) begin
          bpu_pc_o = pc_rel;
        end
      end
      KIND_RET: begin
        redirect = !ras_empty_i;
        if (!ras_empty_i) begin
          bpu_pc_o = ras_top_i;
        end
      end
      default: redirect = 1'b0;
    endcase
  end

  assign bpu_pc_valid_o = fetch_en_i && redirect;
  assign ras_pop_o      = fetch_en_i && (kind_i == KIND_RET) && !ras_empty_i;

endmodule

// ==== logic/return_stack.sv ====
`include "bp_config.svh"

module return_stack (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [`XLEN-1:0] push_data_i,
  input  logic             pop_i,
  output logic [`XLEN-1:0] top_o,
  output logic             empty_o
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);
  localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

  logic [`XLEN-1:0] stack_mem [`RAS_DEPTH];
  logic [PTR_W-1:0] ptr_q;  // index of the top entry
  logic [CNT_W-1:0] count_q;
  logic [PTR_W-1:0] ptr_inc;
  logic [PTR_W-1:0] ptr_dec;
  logic             do_pop;

  // circular wrap, works for non power of two depth too
  assign ptr_inc = (ptr_q == PTR_W'(`RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
  assign ptr_dec = (ptr_q == '0) ? PTR_W'(`RAS_DEPTH - 1) : ptr_q - 1'b1;

  assign do_pop  = pop_i && (count_q != '0);  // pop on empty is dropped
  assign empty_o = (count_q == '0);
  assign top_o   = stack_mem[ptr_q];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else if (push_i && do_pop) begin
      stack_mem[ptr_q] <= push_data_i;  // replace top, depth unchanged
    end else if (push_i) begin
      stack_mem[ptr_inc] <= push_data_i;  // full stack drops its oldest entry
      ptr_q              <= ptr_inc;
      if (count_q != CNT_W'(`RAS_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (do_pop) begin
      ptr_q   <= ptr_dec;
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== logic/branch_predictor.sv ====
`include "bp_config.svh"

module branch_predictor (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               fetch_en_i,
  input  logic [`XLEN-1:0]   pc_i,
  input  bp_pkg::inst_kind_e kind_i,
  input  logic               ex_branch_valid_i,
  input  logic               ex_branch_taken_i,
  input  logic               ex_pdt_true_i,
  input  logic [`XLEN-1:0]   ex_pc_i,
  input  logic [`HISLEN-1:0] ex_history_i,
  output logic               pdt_res_o,
  output logic [`HISLEN-1:0] history_o
);

  import bp_pkg::*;

  localparam int IDX_W = $clog2(`BHT_ENTRIES);

  logic [1:0]         bht_q [`BHT_ENTRIES];
  logic [`HISLEN-1:0] history_q;
  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;
  logic [1:0]         wr_cnt;
  logic [1:0]         wr_cnt_next;
  logic               spec_shift;
  logic               repair;

  // gshare index, word address bits xor history
  assign rd_idx = pc_i[IDX_W+1:2] ^ IDX_W'(history_q);
  assign wr_idx = ex_pc_i[IDX_W+1:2] ^ IDX_W'(ex_history_i);  // history used at fetch

  assign pdt_res_o = bht_q[rd_idx][1];  // msb is the direction
  assign history_o = history_q;

  assign spec_shift = fetch_en_i && (kind_i == KIND_BRANCH);
  assign repair     = ex_branch_valid_i && !ex_pdt_true_i;

  assign wr_cnt = bht_q[wr_idx];

  // saturating 2-bit counter
  always_comb begin
    wr_cnt_next = wr_cnt;
    if (ex_branch_taken_i && wr_cnt != 2'b11) begin
      wr_cnt_next = wr_cnt + 2'd1;
    end else if (!ex_branch_taken_i && wr_cnt != 2'b00) begin
      wr_cnt_next = wr_cnt - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        bht_q[i] <= 2'b01;  // weakly not taken
      end
    end else if (ex_branch_valid_i) begin
      bht_q[wr_idx] <= wr_cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      history_q <= '0;
    end else if (repair) begin
      // mispredict, rebuild from the history the branch saw
      history_q <= {ex_history_i[`HISLEN-2:0], ex_branch_taken_i};
    end else if (spec_shift) begin
      history_q <= {history_q[`HISLEN-2:0], pdt_res_o};  // speculative
    end
  end

endmodule

// ==== logic/inst_predecode.sv ====
`include "bp_config.svh"

module inst_predecode (
  input  logic [`XLEN-1:0]   inst_i,
  output bp_pkg::inst_kind_e kind_o,
  output logic [`XLEN-1:0]   offset_o
);

  import bp_pkg::*;

  opcode_e          opcode;
  logic [4:0]       rd;
  logic [4:0]       rs1;
  logic             link_rs1;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_b;

  assign opcode   = opcode_e'(inst_i[6:0]);
  assign rd       = inst_i[11:7];
  assign rs1      = inst_i[19:15];
  assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);  // ra or t0

  // j-type immediate, bit 0 always zero
  assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // b-type immediate
  assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};

  always_comb begin
    kind_o   = KIND_NONE;
    offset_o = '0;
    case (opcode)
      OP_JAL: begin
        kind_o   = KIND_JAL;
        offset_o = imm_j;
      end
      OP_JALR: begin
        // only returns are predicted, target comes from the stack
        if (rd == 5'd0 && link_rs1) begin
          kind_o = KIND_RET;
        end
      end
      OP_BRANCH: begin
        kind_o   = KIND_BRANCH;
        offset_o = imm_b;
      end
      default: begin
        kind_o   = KIND_NONE;  // everything else falls through
        offset_o = '0;
      end
    endcase
  end

endmodule

// ==== logic/bp_pkg.sv ====
package bp_pkg;

  // predecode result, what the fetched word means for the next pc
  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,  // sequential
    KIND_JAL    = 2'd1,  // direct jump
    KIND_RET    = 2'd2,  // jalr used as return
    KIND_BRANCH = 2'd3   // conditional branch
  } inst_kind_e;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_REG      = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

endpackage

// ==== include/bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// datapath
`define XLEN 32

// gshare global history length
`define HISLEN 4

// counter table size, power of two
`define BHT_ENTRIES 16

// return stack entries
`define RAS_DEPTH 4

// fetch trap bus layout
`define TRAP_LEN 16
`define TRAP_INST_ADDR_MISALIGNED 0
`define TRAP_INST_ACCESS_FAULT 1
`define TRAP_INST_PAGE_FAULT 12

`endif
